//--- hw/qspim_reg_pkg.sv
/*
 * Serial flash master, bus-side definitions
 * Register map, bus widths and configuration types
 */
package qspim_reg_pkg;

    typedef logic [31:0] wb_data_t;   // Bus data word
    typedef logic [3:0]  reg_idx_t;   // Address bits 5:2
    typedef logic [7:0]  clk_div_t;   // Serial clock divider
    typedef logic [3:0]  cs_sel_t;    // One enable per flash

    // ------------------------------------------------------------
    // Register indices
    // ------------------------------------------------------------
    localparam reg_idx_t REG_GLBL_CFG = 4'd0;  // Div 7:0, cs 11:8
    localparam reg_idx_t REG_ADDR     = 4'd1;  // 24-bit flash address
    localparam reg_idx_t REG_CMD      = 4'd2;  // Push header
    localparam reg_idx_t REG_WDATA    = 4'd3;  // Push data word
    localparam reg_idx_t REG_RDATA    = 4'd4;  // Pop response word
    localparam reg_idx_t REG_STATUS   = 4'd5;  // Read only

    localparam clk_div_t CLK_DIV_RST = 8'd1;
    localparam cs_sel_t  CS_SEL_RST  = 4'b0001;

    // STATUS bit positions
    localparam int STAT_BUSY      = 0;
    localparam int STAT_CMD_FULL  = 1;
    localparam int STAT_CMD_EMPTY = 2;
    localparam int STAT_RES_EMPTY = 3;

endpackage

//--- hw/qspim_spi_pkg.sv
/*
 * Serial flash master, SPI-side definitions
 * Command entry layout, FIFO depths and sequencer states
 */
package qspim_spi_pkg;

    typedef logic [7:0]  spi_byte_t;
    typedef logic [23:0] flash_addr_t;
    typedef logic [1:0]  addr_cnt_t;    // 0 to 3 address bytes
    typedef logic [3:0]  byte_cnt_t;    // 0 to 15 data bytes
    typedef logic [39:0] cmd_entry_t;   // One command FIFO entry

    // ------------------------------------------------------------
    // Entry fields, header unless noted
    // ------------------------------------------------------------
    localparam int ENT_TAG      = 39;   // 1 header, 0 data
    localparam int ENT_OPC_LSB  = 31;   // Opcode 38:31
    localparam int ENT_ADDR_LSB = 7;    // Address 30:7
    localparam int ENT_ACNT_LSB = 5;    // Address count 6:5
    localparam int ENT_DIR      = 4;    // 1 read
    localparam int ENT_BCNT_LSB = 0;    // Byte count 3:0
    // Data entry keeps its word in 31:0

    localparam int CMD_FIFO_DEPTH = 4;
    localparam int RES_FIFO_DEPTH = 8;

    typedef enum logic [2:0] {
        ST_IDLE, ST_OPCODE, ST_ADDR, ST_WRITE, ST_READ, ST_STALL, ST_END
    } ctrl_state_t;

endpackage

//--- hw/qspim_fifo.sv
/*
 * Synchronous FIFO, first-word-fall-through read data
 * Circular buffer with occupancy count
 */
`timescale 1ns/100ps

module qspim_fifo #(
    parameter int W     = 32,
    parameter int DEPTH = 4
) (
    input  logic         mclk,
    input  logic         rst_n_i,
    input  logic         wr_en_i,
    input  logic [W-1:0] wr_data_i,
    input  logic         rd_en_i,
    output logic [W-1:0] rd_data_o,
    output logic         full_o,
    output logic         empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [W-1:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;   // Entries held

    // Pointers and count
    always_ff @(posedge mclk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en_i)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en_i)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en_i, rd_en_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither, no change
            endcase
        end
    end

    // Storage
    always_ff @(posedge mclk) begin
        if (wr_en_i)
            mem[wr_ptr] <= wr_data_i;
    end

    assign rd_data_o = mem[rd_ptr];             // Head word, no pop needed
    assign full_o    = (count == (AW + 1)'(DEPTH));
    assign empty_o   = (count == '0);

    // Producer and consumer must honour the flags
    a_no_overflow: assert property (@(posedge mclk) disable iff (!rst_n_i)
        !(wr_en_i && full_o));
    a_no_underflow: assert property (@(posedge mclk) disable iff (!rst_n_i)
        !(rd_en_i && empty_o));

endmodule

//--- hw/qspim_regs.sv
/*
 * Host register block
 * Decodes the bus, holds configuration, feeds the command FIFO
 * and drains the response FIFO with back-pressure on ack
 */
`timescale 1ns/100ps

module qspim_regs (
    input  logic                       mclk,
    input  logic                       rst_n_i,
    // Host bus
    input  logic                       wbd_stb_i,
    input  qspim_reg_pkg::wb_data_t    wbd_adr_i,
    input  logic                       wbd_we_i,
    input  qspim_reg_pkg::wb_data_t    wbd_dat_i,
    input  logic [3:0]                 wbd_sel_i,
    output qspim_reg_pkg::wb_data_t    wbd_dat_o,
    output logic                       wbd_ack_o,
    output logic                       wbd_err_o,
    // Command FIFO
    output logic                       cmd_wr_o,
    output qspim_spi_pkg::cmd_entry_t  cmd_wdata_o,
    input  logic                       cmd_full_i,
    input  logic                       cmd_empty_i,
    // Response FIFO
    output logic                       res_rd_o,
    input  qspim_reg_pkg::wb_data_t    res_rdata_i,
    input  logic                       res_empty_i,
    // Sequencer
    input  logic                       ctrl_busy_i,
    output qspim_reg_pkg::clk_div_t    clk_div_o,
    output qspim_reg_pkg::cs_sel_t     cs_sel_o
);

    qspim_reg_pkg::reg_idx_t     idx;
    logic                        acc_rdy;    // Target can take the access now
    logic                        acc_go;     // Access completes this edge
    logic                        push_cmd;
    qspim_spi_pkg::flash_addr_t  addr_q;     // ADDR register
    qspim_reg_pkg::wb_data_t     status;
    qspim_reg_pkg::wb_data_t     rd_mux;

    assign idx = wbd_adr_i[5:2];

    // ------------------------------------------------------------
    // Access decode and back-pressure
    // ------------------------------------------------------------
    always_comb begin
        case (idx)
            qspim_reg_pkg::REG_CMD,
            qspim_reg_pkg::REG_WDATA: acc_rdy = !wbd_we_i || !cmd_full_i;
            qspim_reg_pkg::REG_RDATA: acc_rdy = wbd_we_i || !res_empty_i;
            default:                  acc_rdy = 1'b1;
        endcase
    end

    // No second access while ack is out and stb is still held
    assign acc_go   = wbd_stb_i && !wbd_ack_o && acc_rdy;
    assign push_cmd = acc_go && wbd_we_i &&
                      (idx == qspim_reg_pkg::REG_CMD || idx == qspim_reg_pkg::REG_WDATA);
    assign cmd_wr_o = push_cmd;
    assign res_rd_o = acc_go && !wbd_we_i && (idx == qspim_reg_pkg::REG_RDATA);

    // Header or data entry
    always_comb begin
        cmd_wdata_o = '0;
        if (idx == qspim_reg_pkg::REG_CMD) begin
            cmd_wdata_o[qspim_spi_pkg::ENT_TAG]           = 1'b1;
            cmd_wdata_o[qspim_spi_pkg::ENT_OPC_LSB +: 8]  = wbd_dat_i[7:0];
            cmd_wdata_o[qspim_spi_pkg::ENT_ADDR_LSB +: 24] = addr_q;
            cmd_wdata_o[qspim_spi_pkg::ENT_ACNT_LSB +: 2] = wbd_dat_i[9:8];
            cmd_wdata_o[qspim_spi_pkg::ENT_DIR]           = wbd_dat_i[10];
            cmd_wdata_o[qspim_spi_pkg::ENT_BCNT_LSB +: 4] = wbd_dat_i[15:12];
        end else begin
            cmd_wdata_o[31:0] = wbd_dat_i;  // Tag stays 0
        end
    end

    // ------------------------------------------------------------
    // Configuration registers with byte enables
    // ------------------------------------------------------------
    always_ff @(posedge mclk) begin
        if (!rst_n_i) begin
            clk_div_o <= qspim_reg_pkg::CLK_DIV_RST;
            cs_sel_o  <= qspim_reg_pkg::CS_SEL_RST;
            addr_q    <= '0;
        end else if (acc_go && wbd_we_i) begin
            if (idx == qspim_reg_pkg::REG_GLBL_CFG) begin
                if (wbd_sel_i[0]) clk_div_o <= wbd_dat_i[7:0];
                if (wbd_sel_i[1]) cs_sel_o  <= wbd_dat_i[11:8];
            end
            if (idx == qspim_reg_pkg::REG_ADDR) begin
                if (wbd_sel_i[0]) addr_q[7:0]   <= wbd_dat_i[7:0];
                if (wbd_sel_i[1]) addr_q[15:8]  <= wbd_dat_i[15:8];
                if (wbd_sel_i[2]) addr_q[23:16] <= wbd_dat_i[23:16];
            end
        end
    end

    // One-cycle ack and error pulses
    always_ff @(posedge mclk) begin
        if (!rst_n_i) begin
            wbd_ack_o <= 1'b0;
            wbd_err_o <= 1'b0;
        end else begin
            wbd_ack_o <= acc_go;
            wbd_err_o <= acc_go && (idx > qspim_reg_pkg::REG_STATUS);  // Unmapped
        end
    end

    // ------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------
    always_comb begin
        status = '0;
        status[qspim_reg_pkg::STAT_BUSY]      = ctrl_busy_i;
        status[qspim_reg_pkg::STAT_CMD_FULL]  = cmd_full_i;
        status[qspim_reg_pkg::STAT_CMD_EMPTY] = cmd_empty_i;
        status[qspim_reg_pkg::STAT_RES_EMPTY] = res_empty_i;
    end

    always_comb begin
        case (idx)
            qspim_reg_pkg::REG_GLBL_CFG: rd_mux = {20'b0, cs_sel_o, clk_div_o};
            qspim_reg_pkg::REG_ADDR:     rd_mux = {8'b0, addr_q};
            qspim_reg_pkg::REG_RDATA:    rd_mux = res_rdata_i;  // FIFO head
            qspim_reg_pkg::REG_STATUS:   rd_mux = status;
            default:                     rd_mux = '0;
        endcase
    end

    always_ff @(posedge mclk) begin
        if (acc_go && !wbd_we_i)
            wbd_dat_o <= rd_mux;
    end

    // A waiting access stays on the bus unchanged until its ack
    a_stb_hold: assert property (@(posedge mclk) disable iff (!rst_n_i)
        (wbd_stb_i && !wbd_ack_o) |=> (wbd_stb_i && $stable(wbd_adr_i) && $stable(wbd_we_i)));

endmodule

//--- hw/qspim_ctrl.sv
/*
 * SPI frame sequencer, mode 0, MSB first, single data line
 * Opcode, address and data phases with FIFO stall handling
 */
`timescale 1ns/100ps

module qspim_ctrl (
    input  logic                       mclk,
    input  logic                       rst_n_i,
    input  qspim_reg_pkg::clk_div_t    clk_div_i,
    input  qspim_reg_pkg::cs_sel_t     cs_sel_i,
    // Command FIFO
    output logic                       cmd_rd_o,
    input  qspim_spi_pkg::cmd_entry_t  cmd_rdata_i,
    input  logic                       cmd_empty_i,
    // Response FIFO
    output logic                       res_wr_o,
    output qspim_reg_pkg::wb_data_t    res_wdata_o,
    input  logic                       res_full_i,
    // Status
    output logic                       ctrl_busy_o,
    // Serial lines
    output logic                       spi_clk_o,
    output logic [3:0]                 spi_csn_o,
    output logic                       spi_sdo_o,
    input  logic                       spi_sdi_i
);

    qspim_spi_pkg::ctrl_state_t  state;
    qspim_reg_pkg::clk_div_t     hcnt;      // Half-period counter
    logic [2:0]                  bit_cnt;
    qspim_spi_pkg::spi_byte_t    sh;        // Shift register
    logic                        sdi_q;     // Bit sampled on rising edge
    qspim_spi_pkg::flash_addr_t  addr_sh;   // Address, next byte on top
    qspim_spi_pkg::addr_cnt_t    acnt;      // Address bytes left
    qspim_spi_pkg::byte_cnt_t    dcnt;      // Data bytes left
    logic                        dir;       // 1 read
    logic [1:0]                  bidx;      // Byte in word, current byte
    qspim_reg_pkg::wb_data_t     word;      // Word being sent or built

    qspim_spi_pkg::spi_byte_t    hdr_opc;
    qspim_spi_pkg::flash_addr_t  hdr_addr;
    qspim_spi_pkg::addr_cnt_t    hdr_acnt;
    qspim_spi_pkg::byte_cnt_t    hdr_bcnt;

    logic       shifting, tick, fall, byte_end;
    logic       sel, addr_go, dat_ok, dat_go;
    logic [1:0] nb;                         // Index of the next data byte

    // Header fields at the FIFO head
    assign hdr_opc  = cmd_rdata_i[qspim_spi_pkg::ENT_OPC_LSB +: 8];
    assign hdr_addr = cmd_rdata_i[qspim_spi_pkg::ENT_ADDR_LSB +: 24];
    assign hdr_acnt = cmd_rdata_i[qspim_spi_pkg::ENT_ACNT_LSB +: 2];
    assign hdr_bcnt = cmd_rdata_i[qspim_spi_pkg::ENT_BCNT_LSB +: 4];

    // ------------------------------------------------------------
    // Byte scheduling
    // ------------------------------------------------------------
    assign shifting = (state == qspim_spi_pkg::ST_OPCODE) || (state == qspim_spi_pkg::ST_ADDR) ||
                      (state == qspim_spi_pkg::ST_WRITE)  || (state == qspim_spi_pkg::ST_READ);
    assign tick     = (hcnt == clk_div_i);
    assign fall     = tick && spi_clk_o;
    assign byte_end = shifting && fall && (bit_cnt == 3'd7);

    // Next byte is chosen at a byte end or while stalled
    assign sel     = byte_end || (state == qspim_spi_pkg::ST_STALL);
    assign nb      = bidx + 2'd1;
    assign dat_ok  = dir ? !(res_full_i && (nb == 2'd3 || dcnt == 4'd1))  // Word completes
                         : !(nb == 2'd0 && cmd_empty_i);                 // New word needed
    assign addr_go = sel && (acnt != '0);
    assign dat_go  = sel && (acnt == '0) && (dcnt != '0) && dat_ok;

    // Pop a header when idle, a data word when the write needs one
    assign cmd_rd_o = ((state == qspim_spi_pkg::ST_IDLE) && !cmd_empty_i) ||
                      (dat_go && !dir && nb == 2'd0);

    // Received byte merged into the word, upper bytes zero on a new word
    always_comb begin
        res_wdata_o = (bidx == 2'd0) ? '0 : word;
        res_wdata_o[{bidx, 3'b000} +: 8] = {sh[6:0], sdi_q};
    end

    assign res_wr_o  = (state == qspim_spi_pkg::ST_READ) && byte_end &&
                       (bidx == 2'd3 || dcnt == '0);
    assign spi_sdo_o = sh[7];

    // ------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------
    always_ff @(posedge mclk) begin
        if (!rst_n_i) begin
            state       <= qspim_spi_pkg::ST_IDLE;
            hcnt        <= '0;
            bit_cnt     <= '0;
            spi_clk_o   <= 1'b0;
            spi_csn_o   <= '1;
            ctrl_busy_o <= 1'b0;
        end else begin
            // Counter only runs while a half period is being timed
            if (state == qspim_spi_pkg::ST_IDLE || state == qspim_spi_pkg::ST_STALL || tick)
                hcnt <= '0;
            else
                hcnt <= hcnt + 1'b1;

            case (state)
                qspim_spi_pkg::ST_IDLE: begin
                    if (!cmd_empty_i && cmd_rdata_i[qspim_spi_pkg::ENT_TAG]) begin
                        state       <= qspim_spi_pkg::ST_OPCODE;
                        bit_cnt     <= '0;
                        spi_csn_o   <= ~cs_sel_i;   // Half period before first clock
                        ctrl_busy_o <= 1'b1;
                    end
                end
                qspim_spi_pkg::ST_STALL: begin
                    if (dat_go)
                        state <= dir ? qspim_spi_pkg::ST_READ : qspim_spi_pkg::ST_WRITE;
                end
                qspim_spi_pkg::ST_END: begin
                    if (tick) begin                     // Half period after last clock
                        state       <= qspim_spi_pkg::ST_IDLE;
                        spi_csn_o   <= '1;
                        ctrl_busy_o <= 1'b0;
                    end
                end
                default: begin
                    if (tick)
                        spi_clk_o <= !spi_clk_o;
                    if (fall)
                        bit_cnt <= bit_cnt + 1'b1;      // Wraps to 0 after bit 7
                    if (byte_end) begin
                        if (acnt != '0)
                            state <= qspim_spi_pkg::ST_ADDR;
                        else if (dcnt == '0)
                            state <= qspim_spi_pkg::ST_END;
                        else if (dat_ok)
                            state <= dir ? qspim_spi_pkg::ST_READ : qspim_spi_pkg::ST_WRITE;
                        else
                            state <= qspim_spi_pkg::ST_STALL;   // Clock low, CS held
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Data path
    // ------------------------------------------------------------
    always_ff @(posedge mclk) begin
        if (state == qspim_spi_pkg::ST_IDLE) begin
            sh      <= hdr_opc;
            addr_sh <= hdr_addr << {2'd3 - hdr_acnt, 3'b000};   // Drop unsent high bytes
            acnt    <= hdr_acnt;
            dcnt    <= hdr_bcnt;
            dir     <= cmd_rdata_i[qspim_spi_pkg::ENT_DIR];
            bidx    <= 2'd3;                                    // First data byte is 0
        end else begin
            if (shifting && tick && !spi_clk_o)
                sdi_q <= spi_sdi_i;                             // Rising edge sample
            if (shifting && fall)
                sh <= {sh[6:0], sdi_q};
            if (addr_go) begin
                sh      <= addr_sh[23:16];
                addr_sh <= {addr_sh[15:0], 8'h00};
                acnt    <= acnt - 1'b1;
            end
            if (dat_go) begin
                bidx <= nb;
                dcnt <= dcnt - 1'b1;
                if (!dir && nb == 2'd0) begin
                    word <= cmd_rdata_i[31:0];
                    sh   <= cmd_rdata_i[7:0];                   // Lowest byte first
                end else if (!dir) begin
                    sh <= word[{nb, 3'b000} +: 8];
                end
            end
            if (state == qspim_spi_pkg::ST_READ && byte_end)
                word <= res_wdata_o;
        end
    end

    // Chip select only asserted inside a frame
    a_csn_idle: assert property (@(posedge mclk) disable iff (!rst_n_i)
        (state == qspim_spi_pkg::ST_IDLE) |-> (spi_csn_o == '1));

endmodule

//--- hw/qspim_top.sv
/*
 * Serial flash master top level
 * Register block, command and response FIFOs, frame sequencer
 */
`timescale 1ns/100ps

module qspim_top (
    input  logic                     mclk,
    input  logic                     rst_n_i,
    // Host bus
    input  logic                     wbd_stb_i,
    input  qspim_reg_pkg::wb_data_t  wbd_adr_i,
    input  logic                     wbd_we_i,
    input  qspim_reg_pkg::wb_data_t  wbd_dat_i,
    input  logic [3:0]               wbd_sel_i,
    output qspim_reg_pkg::wb_data_t  wbd_dat_o,
    output logic                     wbd_ack_o,
    output logic                     wbd_err_o,
    // Flash pins
    output logic                     spi_clk_o,
    output logic [3:0]               spi_csn_o,
    output logic                     spi_sdo_o,
    input  logic                     spi_sdi_i
);

    // Command path
    logic                        cmd_wr, cmd_rd, cmd_full, cmd_empty;
    qspim_spi_pkg::cmd_entry_t   cmd_wdata, cmd_rdata;
    // Response path
    logic                        res_wr, res_rd, res_full, res_empty;
    qspim_reg_pkg::wb_data_t     res_wdata, res_rdata;
    // Configuration and status
    qspim_reg_pkg::clk_div_t     clk_div;
    qspim_reg_pkg::cs_sel_t      cs_sel;
    logic                        ctrl_busy;

    qspim_regs u_regs (
        .mclk        (mclk),        .rst_n_i     (rst_n_i),
        .wbd_stb_i   (wbd_stb_i),   .wbd_adr_i   (wbd_adr_i),
        .wbd_we_i    (wbd_we_i),    .wbd_dat_i   (wbd_dat_i),
        .wbd_sel_i   (wbd_sel_i),   .wbd_dat_o   (wbd_dat_o),
        .wbd_ack_o   (wbd_ack_o),   .wbd_err_o   (wbd_err_o),
        .cmd_wr_o    (cmd_wr),      .cmd_wdata_o (cmd_wdata),
        .cmd_full_i  (cmd_full),    .cmd_empty_i (cmd_empty),
        .res_rd_o    (res_rd),      .res_rdata_i (res_rdata),
        .res_empty_i (res_empty),   .ctrl_busy_i (ctrl_busy),
        .clk_div_o   (clk_div),     .cs_sel_o    (cs_sel)
    );

    qspim_fifo #(.W(40), .DEPTH(qspim_spi_pkg::CMD_FIFO_DEPTH)) u_cmd_fifo (
        .mclk (mclk), .rst_n_i (rst_n_i),
        .wr_en_i (cmd_wr), .wr_data_i (cmd_wdata),
        .rd_en_i (cmd_rd), .rd_data_o (cmd_rdata),
        .full_o (cmd_full), .empty_o (cmd_empty)
    );

    qspim_fifo #(.W(32), .DEPTH(qspim_spi_pkg::RES_FIFO_DEPTH)) u_res_fifo (
        .mclk (mclk), .rst_n_i (rst_n_i),
        .wr_en_i (res_wr), .wr_data_i (res_wdata),
        .rd_en_i (res_rd), .rd_data_o (res_rdata),
        .full_o (res_full), .empty_o (res_empty)
    );

    qspim_ctrl u_ctrl (
        .mclk        (mclk),        .rst_n_i     (rst_n_i),
        .clk_div_i   (clk_div),     .cs_sel_i    (cs_sel),
        .cmd_rd_o    (cmd_rd),      .cmd_rdata_i (cmd_rdata),
        .cmd_empty_i (cmd_empty),   .res_wr_o    (res_wr),
        .res_wdata_o (res_wdata),   .res_full_i  (res_full),
        .ctrl_busy_o (ctrl_busy),   .spi_clk_o   (spi_clk_o),
        .spi_csn_o   (spi_csn_o),   .spi_sdo_o   (spi_sdo_o),
        .spi_sdi_i   (spi_sdi_i)
    );

endmodule

//--- tests/spi_flash_model.sv
/*
 * Behavioral serial flash, SPI mode 0
 * Opcode 02h writes and 03h reads
 * Unwritten bytes read as the XOR of all address bytes and A5h
 */
`timescale 1ns/100ps

module spi_flash_model (
    input  logic       csn_i,      // One select line
    input  logic       sclk_i,
    input  logic       mosi_i,
    input  logic [1:0] acnt_i,     // Address bytes in this frame
    output logic       miso_o
);

    logic [7:0]  mem [logic [23:0]];   // Sparse byte memory
    logic [7:0]  rx;
    logic [7:0]  tx;
    logic [2:0]  bcnt;                 // Bit in byte
    int          byte_idx;             // Bytes seen in frame
    logic [7:0]  opc;
    logic [23:0] addr;
    logic [23:0] wr_off;
    logic [23:0] rd_off;

    initial miso_o = 1'b0;

    function automatic logic [7:0] mem_rd(input logic [23:0] a);
        if (mem.exists(a))
            return mem[a];
        return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5;   // Fill pattern over the whole address
    endfunction

    // Clock rests low so a falling select starts a frame
    always @(posedge sclk_i or negedge csn_i) begin
        if (!sclk_i) begin
            bcnt     = '0;
            byte_idx = 0;
            addr     = '0;              // Unsent upper bytes stay zero
            wr_off   = '0;
        end else if (!csn_i) begin
            rx = {rx[6:0], mosi_i};
            if (bcnt == 3'd7) begin
                if (byte_idx == 0)
                    opc = rx;
                else if (byte_idx <= int'(acnt_i))
                    addr = {addr[15:0], rx};
                else if (opc == 8'h02) begin
                    mem[addr + wr_off] = rx;
                    wr_off = wr_off + 24'd1;
                end
                byte_idx = byte_idx + 1;
            end
            bcnt = bcnt + 3'd1;
        end
    end

    // Next bit driven on the falling edge
    always @(negedge sclk_i) begin
        if (!csn_i && opc == 8'h03 && byte_idx > int'(acnt_i)) begin
            if (bcnt == 3'd0) begin      // New byte starts
                tx = mem_rd(addr + rd_off);
                rd_off = rd_off + 24'd1;
            end
            miso_o = tx[7];
            tx = {tx[6:0], 1'b0};
        end else begin
            rd_off = '0;
        end
    end

endmodule

//--- tests/tb_qspim_top.sv
/*
 * Testbench for the serial flash master
 * Register access, table-driven frames, back-pressure cases
 */
`timescale 1ns/100ps

module tb_qspim_top;

    localparam int N_ROWS  = 9;
    localparam int DIV_RUN = 2;                       // Divider after config test
    localparam int STALL_WAIT = 20 * 16 * (DIV_RUN + 1);
    // Per row the opcode, address, data byte count and address byte count
    // Write rows get read back at the same address
    localparam logic [7:0]  T_OPC  [N_ROWS] = '{8'h02, 8'h02, 8'h02, 8'h02, 8'h02,
                                                8'h03, 8'h03, 8'h03, 8'h03};
    localparam logic [23:0] T_ADDR [N_ROWS] = '{24'h123400, 24'h123410, 24'h12341F,
                                                24'h200000, 24'h300001, 24'h400020,
                                                24'h5A5A40, 24'h777788, 24'h000000};
    localparam int          T_LEN  [N_ROWS] = '{1, 4, 7, 15, 10, 6, 9, 5, 3};
    localparam logic [1:0]  T_ACNT [N_ROWS] = '{2'd3, 2'd3, 2'd3, 2'd3, 2'd3,
                                                2'd3, 2'd2, 2'd1, 2'd0};

    logic        mclk, rst_n;
    logic        stb, we;
    logic [31:0] adr, dat_w;
    logic [3:0]  sel;
    logic [31:0] dat_r;
    logic        ack, err;
    logic        spi_clk, spi_sdo, spi_sdi, flash_csn;
    logic [3:0]  spi_csn;
    logic [1:0]  model_acnt;
    logic [1:0]  cs_idx;
    logic [3:0]  exp_cs;
    logic [31:0] lcg_s;
    logic [7:0]  exp_b [64];                          // Expected bytes of a frame
    int          cycles, limit, csn_low_cycles;

    qspim_top i_dut (
        .mclk (mclk), .rst_n_i (rst_n),
        .wbd_stb_i (stb), .wbd_adr_i (adr), .wbd_we_i (we), .wbd_dat_i (dat_w),
        .wbd_sel_i (sel), .wbd_dat_o (dat_r), .wbd_ack_o (ack), .wbd_err_o (err),
        .spi_clk_o (spi_clk), .spi_csn_o (spi_csn), .spi_sdo_o (spi_sdo),
        .spi_sdi_i (spi_sdi)
    );

    assign flash_csn = spi_csn[cs_idx];

    spi_flash_model u_flash (
        .csn_i (flash_csn), .sclk_i (spi_clk), .mosi_i (spi_sdo),
        .acnt_i (model_acnt), .miso_o (spi_sdi)
    );

    initial mclk = 1'b0;
    always #10 mclk = !mclk;

    // ------------------------------------------------------------
    // Checker, LCG, watchdog
    // ------------------------------------------------------------
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("error %s exp %h got %h", name, exp, got);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run took longer than its cycle limit");
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    // Only the selected flash may see its select low
    always @(negedge mclk) begin
        if (rst_n && spi_csn !== 4'hF) begin
            check("spi_csn_o", {28'h0, ~exp_cs}, {28'h0, spi_csn});
            csn_low_cycles = csn_low_cycles + 1;
        end
    end

    // ------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------
    task automatic bus_write(input logic [3:0] idx, input logic [31:0] d,
                             input logic [3:0] be, output logic e);
        @(posedge mclk);
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= {26'h0, idx, 2'b00};
        dat_w <= d;
        sel   <= be;
        do @(negedge mclk); while (!ack);
        e = err;
        @(posedge mclk);
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] idx, output logic [31:0] d, output logic e);
        @(posedge mclk);
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= {26'h0, idx, 2'b00};
        sel <= 4'hF;
        do @(negedge mclk); while (!ack);
        d = dat_r;
        e = err;
        @(posedge mclk);
        stb <= 1'b0;
    endtask

    // Polls until the sequencer is idle with nothing queued
    task automatic wait_idle();
        logic [31:0] st;
        logic        e;
        do bus_read(qspim_reg_pkg::REG_STATUS, st, e); while (st[0] || !st[2]);
    endtask

    task automatic send_header(input logic [7:0] opc, input logic [23:0] a,
                               input logic [1:0] acnt, input int len);
        logic e;
        model_acnt = acnt;
        bus_write(qspim_reg_pkg::REG_ADDR, {8'h0, a}, 4'b0111, e);
        bus_write(qspim_reg_pkg::REG_CMD,
                  {16'h0, len[3:0], 1'b0, opc == 8'h03, acnt, opc}, 4'hF, e);
    endtask

    // Fresh LCG words with their bytes recorded lowest first
    task automatic push_words(input int len);
        logic e;
        for (int w = 0; w < (len + 3) / 4; w++) begin
            lcg_s = lcg_next(lcg_s);
            for (int k = 0; k < 4; k++)
                exp_b[4 * w + k] = lcg_s[8 * k +: 8];
            bus_write(qspim_reg_pkg::REG_WDATA, lcg_s, 4'hF, e);
        end
    endtask

    // Pops response words with a zero-filled partial last word
    task automatic read_words(input int len);
        logic [31:0] d, exp;
        logic        e;
        for (int w = 0; w < (len + 3) / 4; w++) begin
            bus_read(qspim_reg_pkg::REG_RDATA, d, e);
            for (int k = 0; k < 4; k++)
                exp[8 * k +: 8] = (4 * w + k < len) ? exp_b[4 * w + k] : 8'h00;
            check("wbd_dat_o", exp, d);
        end
    endtask

    function automatic logic [23:0] eff_addr(input logic [23:0] a, input logic [1:0] acnt);
        case (acnt)
            2'd0:    return 24'h0;
            2'd1:    return {16'h0, a[7:0]};
            2'd2:    return {8'h0, a[15:0]};
            default: return a;
        endcase
    endfunction

    task automatic fill_pattern(input logic [23:0] a, input int len);
        logic [23:0] b;
        for (int k = 0; k < len; k++) begin
            b = a + 24'(k);
            exp_b[k] = b[23:16] ^ b[15:8] ^ b[7:0] ^ 8'hA5;   // Unwritten flash byte
        end
    endtask

    task automatic read_frame(input logic [23:0] a, input logic [1:0] acnt, input int len);
        int c0;
        c0 = csn_low_cycles;
        send_header(8'h03, a, acnt, len);
        read_words(len);
        wait_idle();
        check("csn_active", 32'd1, 32'(csn_low_cycles > c0));
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] d;
        logic        e;
        int          nbytes, nframes;
        rst_n = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        sel = '0;
        model_acnt = 2'd3;
        cs_idx = 2'd0;
        exp_cs = qspim_reg_pkg::CS_SEL_RST;
        lcg_s = 32'hb39e4241;
        cycles = 0;
        csn_low_cycles = 0;
        nbytes = 65;                                  // Back-pressure frames
        nframes = 6;
        for (int r = 0; r < N_ROWS; r++) begin
            nbytes += (T_OPC[r] == 8'h02) ? 2 * T_LEN[r] : T_LEN[r];
            nframes += (T_OPC[r] == 8'h02) ? 2 : 1;
        end
        limit = (nbytes + 4 * nframes) * 16 * (DIV_RUN + 1) * 2 + 2000;
        repeat (16) @(posedge mclk);
        rst_n <= 1'b1;

        // Reset state
        bus_read(qspim_reg_pkg::REG_STATUS, d, e);
        check("status", 32'h0000_000C, d);
        check("spi_csn_o", 32'hF, {28'h0, spi_csn});
        check("spi_clk_o", 32'd0, {31'h0, spi_clk});
        bus_read(qspim_reg_pkg::REG_GLBL_CFG, d, e);
        check("glbl_cfg", 32'h0000_0101, d);
        check("wbd_err_o", 32'd0, {31'h0, e});
        bus_read(4'd9, d, e);
        check("wbd_err_o", 32'd1, {31'h0, e});

        // Byte enables on chip select then on divider
        bus_write(qspim_reg_pkg::REG_GLBL_CFG, 32'hFFFF_04FF, 4'b0010, e);
        bus_read(qspim_reg_pkg::REG_GLBL_CFG, d, e);
        check("glbl_cfg", 32'h0000_0401, d);
        exp_cs = 4'b0100;
        cs_idx = 2'd2;
        bus_write(qspim_reg_pkg::REG_GLBL_CFG, 32'hAAAA_AA00 | DIV_RUN, 4'b0001, e);
        bus_read(qspim_reg_pkg::REG_GLBL_CFG, d, e);
        check("glbl_cfg", 32'h0000_0400 | DIV_RUN, d);

        // Table of frames
        for (int r = 0; r < N_ROWS; r++) begin
            if (T_OPC[r] == 8'h02) begin
                send_header(8'h02, T_ADDR[r], T_ACNT[r], T_LEN[r]);
                push_words(T_LEN[r]);
                wait_idle();
            end else begin
                fill_pattern(eff_addr(T_ADDR[r], T_ACNT[r]), T_LEN[r]);
            end
            read_frame(T_ADDR[r], T_ACNT[r], T_LEN[r]);
        end

        // Three queued reads fill the response FIFO and stall the third frame
        for (int f = 0; f < 3; f++)
            send_header(8'h03, 24'h600000 + 24'(16 * f), 2'd3, 15);
        do bus_read(qspim_reg_pkg::REG_STATUS, d, e); while (!d[2]);
        repeat (STALL_WAIT) @(posedge mclk);
        bus_read(qspim_reg_pkg::REG_STATUS, d, e);
        check("status_busy", 32'd1, {31'h0, d[0]});
        check("status_res_empty", 32'd0, {31'h0, d[3]});
        for (int f = 0; f < 3; f++) begin
            fill_pattern(24'h600000 + 24'(16 * f), 15);
            read_words(15);
        end
        wait_idle();

        // Write header ahead of its data
        send_header(8'h02, 24'h700000, 2'd3, 8);
        do bus_read(qspim_reg_pkg::REG_STATUS, d, e); while (!d[0]);
        push_words(8);
        wait_idle();
        read_frame(24'h700000, 2'd3, 8);

        // RDATA read waits for the word
        fill_pattern(24'h650000, 4);
        send_header(8'h03, 24'h650000, 2'd3, 4);
        read_words(4);
        wait_idle();

        $display("test passed");
        $finish;
    end

endmodule

//--- src.f
hw/qspim_reg_pkg.sv
hw/qspim_spi_pkg.sv
hw/qspim_fifo.sv
hw/qspim_regs.sv
hw/qspim_ctrl.sv
hw/qspim_top.sv
tests/spi_flash_model.sv
tests/tb_qspim_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_qspim_top -o sim_tb
./obj_dir/sim_tb
